//--- verilog/rvmini_pkg.sv
// shared types for the RV64I mini pipeline; the pc is 32 bits wide and zero-extended into 64-bit data paths
package rvmini_pkg;

    typedef logic [63:0] xlen_t;      // register and data word
    typedef logic [31:0] addr_t;      // instruction address
    typedef logic [31:0] inst_t;      // instruction word
    typedef logic [4:0]  reg_addr_t;  // register index

    // ALU operations; pass_b forwards operand b (LUI)
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_e;

    // major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // funct fields used by decode
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_SUB     = 7'b0100000;

    localparam inst_t INST_EBREAK = 32'h0010_0073;

    localparam addr_t RESET_PC   = 32'h0000_0000;
    localparam addr_t INST_BYTES = 32'd4;  // pc step per instruction

endpackage

//--- verilog/rvmini_pipe_if.sv
// pipeline register bundles; every field is registered by the producing stage, no handshake

interface id_ex_if;
    logic                  valid;
    rvmini_pkg::addr_t     pc;
    rvmini_pkg::reg_addr_t rd;
    logic                  wen;
    rvmini_pkg::xlen_t     op_a;       // rs1 value, forwarded
    rvmini_pkg::xlen_t     op_b;       // rs2 value or immediate
    rvmini_pkg::xlen_t     imm;        // branch and jump offset
    rvmini_pkg::alu_op_e   alu_op;
    logic                  is_branch;
    logic                  branch_ne;  // bne, else beq
    logic                  is_jal;
    logic                  is_ebreak;
    logic                  unknown;

    modport decode (output valid, pc, rd, wen, op_a, op_b, imm, alu_op,
                    is_branch, branch_ne, is_jal, is_ebreak, unknown);
    modport execute (input valid, pc, rd, wen, op_a, op_b, imm, alu_op,
                     is_branch, branch_ne, is_jal, is_ebreak, unknown);
endinterface

interface ex_wb_if;
    logic                  valid;
    rvmini_pkg::addr_t     pc;
    rvmini_pkg::reg_addr_t rd;
    logic                  wen;
    rvmini_pkg::xlen_t     data;
    logic                  unknown;
    logic                  ebreak;

    modport execute (output valid, pc, rd, wen, data, unknown, ebreak);
    modport write (input valid, pc, rd, wen, data, unknown, ebreak);
endinterface

//--- verilog/fetch_stage.sv
// fetch stage; inst_i must return the word at pc_o in the same cycle, halt has priority over redirect
module fetch_stage (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              redirect_i,
    input  rvmini_pkg::addr_t redirect_pc_i,
    input  logic              halt_req_i,
    output rvmini_pkg::addr_t pc_o,
    input  rvmini_pkg::inst_t inst_i,
    output logic              if_valid_o,
    output rvmini_pkg::addr_t if_pc_o,
    output rvmini_pkg::inst_t if_inst_o
);

    rvmini_pkg::addr_t pc_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= rvmini_pkg::RESET_PC;
        end else if (halt_req_i) begin
            pc_q <= pc_q;                        // frozen until reset
        end else if (redirect_i) begin
            pc_q <= redirect_pc_i;
        end else begin
            pc_q <= pc_q + rvmini_pkg::INST_BYTES;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            if_valid_o <= 1'b0;
        end else begin
            if_valid_o <= !(redirect_i || halt_req_i);  // wrong-path word dropped
        end
        if_pc_o   <= pc_q;
        if_inst_o <= inst_i;
    end

    assign pc_o = pc_q;

    // targets come from immediates, so an odd offset would show up here
    a_pc_aligned : assert property (@(posedge clk) disable iff (reset_i)
        pc_o[1:0] == 2'b00)
        else $error("pc_o not word aligned: %h", pc_o);

endmodule

//--- verilog/decode_stage.sv
// decode stage; unsupported encodings retire as unknown no-ops and forwarding avoids any stall
module decode_stage (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  if_valid_i,
    input  rvmini_pkg::addr_t     if_pc_i,
    input  rvmini_pkg::inst_t     if_inst_i,
    input  logic                  flush_i,
    output rvmini_pkg::reg_addr_t rs1_addr_o,
    output rvmini_pkg::reg_addr_t rs2_addr_o,
    input  rvmini_pkg::xlen_t     rs1_data_i,
    input  rvmini_pkg::xlen_t     rs2_data_i,
    input  rvmini_pkg::xlen_t     ex_result_i,
    id_ex_if.decode               ex,
    ex_wb_if.write                wb
);

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    rvmini_pkg::reg_addr_t rd;
    rvmini_pkg::xlen_t     imm_i, imm_u, imm_b, imm_j;
    rvmini_pkg::xlen_t     imm;
    rvmini_pkg::alu_op_e   alu_op;
    logic                  wen, use_imm, is_branch, branch_ne, is_jal, is_ebreak, unknown;
    rvmini_pkg::xlen_t     rs1_val, rs2_val;

    assign opcode     = if_inst_i[6:0];
    assign rd         = if_inst_i[11:7];
    assign funct3     = if_inst_i[14:12];
    assign funct7     = if_inst_i[31:25];
    assign rs1_addr_o = if_inst_i[19:15];
    assign rs2_addr_o = if_inst_i[24:20];

    assign imm_i = {{52{if_inst_i[31]}}, if_inst_i[31:20]};
    assign imm_u = {{32{if_inst_i[31]}}, if_inst_i[31:12], 12'b0};
    assign imm_b = {{51{if_inst_i[31]}}, if_inst_i[31], if_inst_i[7],
                    if_inst_i[30:25], if_inst_i[11:8], 1'b0};
    assign imm_j = {{43{if_inst_i[31]}}, if_inst_i[31], if_inst_i[19:12],
                    if_inst_i[20], if_inst_i[30:21], 1'b0};

    always_comb begin
        alu_op    = rvmini_pkg::ALU_ADD;
        imm       = imm_i;
        wen       = 1'b0;
        use_imm   = 1'b0;
        is_branch = 1'b0;
        branch_ne = 1'b0;
        is_jal    = 1'b0;
        is_ebreak = 1'b0;
        unknown   = 1'b0;
        case (opcode)
            rvmini_pkg::OPC_OP: begin
                wen = 1'b1;
                if (funct7 == rvmini_pkg::F7_SUB && funct3 == rvmini_pkg::F3_ADD_SUB)
                    alu_op = rvmini_pkg::ALU_SUB;
                else if (funct7 != rvmini_pkg::F7_BASE)
                    unknown = 1'b1;
                else if (funct3 == rvmini_pkg::F3_ADD_SUB)
                    alu_op = rvmini_pkg::ALU_ADD;
                else if (funct3 == rvmini_pkg::F3_AND)
                    alu_op = rvmini_pkg::ALU_AND;
                else if (funct3 == rvmini_pkg::F3_OR)
                    alu_op = rvmini_pkg::ALU_OR;
                else if (funct3 == rvmini_pkg::F3_XOR)
                    alu_op = rvmini_pkg::ALU_XOR;
                else
                    unknown = 1'b1;
            end
            rvmini_pkg::OPC_OP_IMM: begin
                wen     = 1'b1;
                use_imm = 1'b1;
                unknown = (funct3 != rvmini_pkg::F3_ADD_SUB);  // addi only
            end
            rvmini_pkg::OPC_LUI: begin
                wen     = 1'b1;
                use_imm = 1'b1;
                imm     = imm_u;
                alu_op  = rvmini_pkg::ALU_PASS_B;
            end
            rvmini_pkg::OPC_BRANCH: begin
                imm       = imm_b;
                is_branch = (funct3 == rvmini_pkg::F3_BEQ) || (funct3 == rvmini_pkg::F3_BNE);
                branch_ne = (funct3 == rvmini_pkg::F3_BNE);
                unknown   = !is_branch;
            end
            rvmini_pkg::OPC_JAL: begin
                wen    = 1'b1;
                imm    = imm_j;
                is_jal = 1'b1;
            end
            rvmini_pkg::OPC_SYSTEM: begin
                is_ebreak = (if_inst_i == rvmini_pkg::INST_EBREAK);
                unknown   = !is_ebreak;
            end
            default: unknown = 1'b1;
        endcase
        if (unknown)
            wen = 1'b0;  // unknown word becomes a no-op
    end

    // execute result wins over the write-through register file read
    always_comb begin
        if (ex.valid && ex.wen && ex.rd != '0 && ex.rd == rs1_addr_o)
            rs1_val = ex_result_i;
        else
            rs1_val = rs1_data_i;
        if (ex.valid && ex.wen && ex.rd != '0 && ex.rd == rs2_addr_o)
            rs2_val = ex_result_i;
        else
            rs2_val = rs2_data_i;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ex.valid <= 1'b0;
        end else begin
            ex.valid <= if_valid_i && !flush_i;  // flushed slot becomes a bubble
        end
        ex.pc        <= if_pc_i;
        ex.rd        <= rd;
        ex.wen       <= wen;
        ex.op_a      <= rs1_val;
        ex.op_b      <= use_imm ? imm : rs2_val;
        ex.imm       <= imm;
        ex.alu_op    <= alu_op;
        ex.is_branch <= is_branch;
        ex.branch_ne <= branch_ne;
        ex.is_jal    <= is_jal;
        ex.is_ebreak <= is_ebreak;
        ex.unknown   <= unknown;
    end

    // checked two stages later, where the write actually happens
    a_unknown_no_write : assert property (@(posedge clk) disable iff (reset_i)
        wb.valid && wb.unknown |-> !wb.wen)
        else $error("unknown instruction at %h has write enable set", wb.pc);

endmodule

//--- verilog/execute_stage.sv
// execute stage; branches and jumps resolve here and flush two younger slots, ebreak halts until reset
module execute_stage (
    input  logic              clk,
    input  logic              reset_i,
    id_ex_if.execute          id,
    ex_wb_if.execute          wb,
    output rvmini_pkg::xlen_t result_o,
    output logic              redirect_o,
    output rvmini_pkg::addr_t redirect_pc_o,
    output logic              halt_req_o
);

    rvmini_pkg::xlen_t alu_res;
    rvmini_pkg::addr_t pc_plus4;
    logic              taken;
    logic              halt_q;

    always_comb begin
        case (id.alu_op)
            rvmini_pkg::ALU_ADD: alu_res = id.op_a + id.op_b;
            rvmini_pkg::ALU_SUB: alu_res = id.op_a - id.op_b;
            rvmini_pkg::ALU_AND: alu_res = id.op_a & id.op_b;
            rvmini_pkg::ALU_OR:  alu_res = id.op_a | id.op_b;
            rvmini_pkg::ALU_XOR: alu_res = id.op_a ^ id.op_b;
            default:             alu_res = id.op_b;  // lui
        endcase
    end

    assign pc_plus4 = id.pc + rvmini_pkg::INST_BYTES;
    assign result_o = id.is_jal ? {32'd0, pc_plus4} : alu_res;  // link value for jal

    assign taken         = id.is_branch && ((id.op_a == id.op_b) ^ id.branch_ne);
    assign redirect_o    = id.valid && (taken || id.is_jal || id.is_ebreak);
    assign redirect_pc_o = id.pc + id.imm[31:0];
    assign halt_req_o    = halt_q || (id.valid && id.is_ebreak);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            halt_q   <= 1'b0;
            wb.valid <= 1'b0;
        end else begin
            halt_q   <= halt_req_o;  // sticky once ebreak is seen
            wb.valid <= id.valid;
        end
        wb.pc      <= id.pc;
        wb.rd      <= id.rd;
        wb.wen     <= id.wen;
        wb.data    <= result_o;
        wb.unknown <= id.unknown;
        wb.ebreak  <= id.is_ebreak;
    end

    // decode flushes on the redirect, so a bubble must follow it here
    a_redirect_valid : assert property (@(posedge clk) disable iff (reset_i)
        redirect_o |-> id.valid ##1 !id.valid)
        else $error("redirect without valid instruction or not followed by a bubble");

endmodule

//--- verilog/reg_file.sv
// 32 x 64-bit register file; x0 is never written, reads see the value written back in the same cycle
module reg_file (
    input  logic                  clk,
    input  logic                  reset_i,
    input  rvmini_pkg::reg_addr_t rs1_addr_i,
    input  rvmini_pkg::reg_addr_t rs2_addr_i,
    output rvmini_pkg::xlen_t     rs1_data_o,
    output rvmini_pkg::xlen_t     rs2_data_o,
    ex_wb_if.write                wb
);

    rvmini_pkg::xlen_t regs_q [0:31];
    logic              wr_en;

    assign wr_en = wb.valid && wb.wen && wb.rd != '0;  // x0 stays zero

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[wb.rd] <= wb.data;
        end
    end

    // write-through read
    assign rs1_data_o = (wr_en && wb.rd == rs1_addr_i) ? wb.data : regs_q[rs1_addr_i];
    assign rs2_data_o = (wr_en && wb.rd == rs2_addr_i) ? wb.data : regs_q[rs2_addr_i];

    a_x0_zero : assert property (@(posedge clk) disable iff (reset_i)
        (rs1_addr_i == '0 -> rs1_data_o == '0) && (rs2_addr_i == '0 -> rs2_data_o == '0))
        else $error("read of x0 returned nonzero data");

endmodule

//--- verilog/rvmini_top.sv
// four-stage RV64I subset top; inst_i is a combinational read of pc_o, retire port shows write-back
module rvmini_top (
    input  logic                  clk,
    input  logic                  reset_i,
    output rvmini_pkg::addr_t     pc_o,
    input  rvmini_pkg::inst_t     inst_i,
    output logic                  retire_valid_o,
    output rvmini_pkg::addr_t     retire_pc_o,
    output rvmini_pkg::reg_addr_t retire_rd_o,
    output rvmini_pkg::xlen_t     retire_data_o,
    output logic                  unknown_o,
    output logic                  halted_o
);

    logic                  if_valid;
    rvmini_pkg::addr_t     if_pc;
    rvmini_pkg::inst_t     if_inst;
    logic                  redirect;
    rvmini_pkg::addr_t     redirect_pc;
    logic                  halt_req;
    rvmini_pkg::reg_addr_t rs1_addr, rs2_addr;
    rvmini_pkg::xlen_t     rs1_data, rs2_data;
    rvmini_pkg::xlen_t     ex_result;
    logic                  halted_q;

    id_ex_if id_ex ();
    ex_wb_if ex_wb ();

    fetch_stage u_fetch (
        .clk(clk), .reset_i(reset_i),
        .redirect_i(redirect), .redirect_pc_i(redirect_pc), .halt_req_i(halt_req),
        .pc_o(pc_o), .inst_i(inst_i),
        .if_valid_o(if_valid), .if_pc_o(if_pc), .if_inst_o(if_inst)
    );

    decode_stage u_decode (
        .clk(clk), .reset_i(reset_i),
        .if_valid_i(if_valid), .if_pc_i(if_pc), .if_inst_i(if_inst),
        .flush_i(redirect),
        .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .ex_result_i(ex_result),
        .ex(id_ex.decode), .wb(ex_wb.write)
    );

    execute_stage u_execute (
        .clk(clk), .reset_i(reset_i),
        .id(id_ex.execute), .wb(ex_wb.execute),
        .result_o(ex_result),
        .redirect_o(redirect), .redirect_pc_o(redirect_pc), .halt_req_o(halt_req)
    );

    reg_file u_reg_file (
        .clk(clk), .reset_i(reset_i),
        .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
        .wb(ex_wb.write)
    );

    always_ff @(posedge clk) begin
        if (reset_i) begin
            halted_q <= 1'b0;
        end else if (ex_wb.valid && ex_wb.ebreak) begin
            halted_q <= 1'b1;  // held until reset
        end
    end

    assign retire_valid_o = ex_wb.valid;
    assign retire_pc_o    = ex_wb.pc;
    assign retire_rd_o    = (ex_wb.valid && ex_wb.wen) ? ex_wb.rd : '0;  // zero when no write
    assign retire_data_o  = ex_wb.data;
    assign unknown_o      = ex_wb.valid && ex_wb.unknown;
    assign halted_o       = halted_q;

endmodule

//--- verification/rvmini_tb.sv
// runs one fixed program from pc 0 that must fit in 64 words and end in ebreak; fetch is served combinationally
module rvmini_tb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef enum int {
        K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_ADDI, K_LUI,
        K_BEQ, K_BNE, K_JAL, K_EBREAK, K_BAD, K_FILL
    } kind_e;

    logic                  clk = 1'b0;
    logic                  reset_i = 1'b1;
    rvmini_pkg::addr_t     pc_o;
    rvmini_pkg::inst_t     inst_i;
    logic                  retire_valid_o;
    rvmini_pkg::addr_t     retire_pc_o;
    rvmini_pkg::reg_addr_t retire_rd_o;
    rvmini_pkg::xlen_t     retire_data_o;
    logic                  unknown_o;
    logic                  halted_o;

    logic [31:0] prog [0:63];  // instruction words
    kind_e       kind_a [0:63];  // what each word means to the model
    logic [4:0]  rd_a [0:63];
    logic [4:0]  rs1_a [0:63];
    logic [4:0]  rs2_a [0:63];
    logic [31:0] imm_a [0:63];
    bit          poison [0:63];  // words that must never retire
    int          n_words;
    integer      seed;
    int          errors;

    logic [31:0] exp_pc [$];
    logic [4:0]  exp_rd [$];
    logic [63:0] exp_data [$];
    bit          exp_unk [$];
    int          exp_gap [$];  // bubbles expected after this retirement

    logic [31:0] e_pc;
    logic [4:0]  e_rd;
    logic [63:0] e_data;
    bit          e_unk;
    int          last_gap;
    int          bubbles = 0;
    int          retired = 0;

    always #50 clk = ~clk;

    assign inst_i = prog[pc_o[7:2]];  // same-cycle fetch

    rvmini_top dut0 (
        .clk(clk), .reset_i(reset_i),
        .pc_o(pc_o), .inst_i(inst_i),
        .retire_valid_o(retire_valid_o), .retire_pc_o(retire_pc_o),
        .retire_rd_o(retire_rd_o), .retire_data_o(retire_data_o),
        .unknown_o(unknown_o), .halted_o(halted_o)
    );

    task add_inst(input kind_e kind, input logic [4:0] rd, input logic [4:0] rs1,
                  input logic [4:0] rs2, input logic [31:0] imm);
        logic [31:0] w;
        case (kind)
            K_ADD:    w = {7'h00, rs2, rs1, 3'b000, rd, 7'b0110011};
            K_SUB:    w = {7'h20, rs2, rs1, 3'b000, rd, 7'b0110011};
            K_AND:    w = {7'h00, rs2, rs1, 3'b111, rd, 7'b0110011};
            K_OR:     w = {7'h00, rs2, rs1, 3'b110, rd, 7'b0110011};
            K_XOR:    w = {7'h00, rs2, rs1, 3'b100, rd, 7'b0110011};
            K_ADDI:   w = {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
            K_LUI:    w = {imm[19:0], rd, 7'b0110111};
            K_BEQ:    w = {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
            K_BNE:    w = {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], 7'b1100011};
            K_JAL:    w = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
            K_EBREAK: w = 32'h0010_0073;
            default:  w = 32'hffff_ffff;  // opcode 7f is not in the subset
        endcase
        prog[n_words]   = w;
        kind_a[n_words] = kind;
        rd_a[n_words]   = rd;
        rs1_a[n_words]  = rs1;
        rs2_a[n_words]  = rs2;
        imm_a[n_words]  = imm;
        poison[n_words] = 1'b0;
        n_words++;
    endtask

    // wrong-path word behind a taken branch or jump
    task add_skipped_word;
        add_inst(K_ADDI, 13, 0, 0, 32'h0bd);
        poison[n_words - 1] = 1'b1;
    endtask

    task build_program;
        logic [31:0] r;
        for (int i = 0; i < 64; i++) begin
            prog[i]   = (i * 32'h9e37_79b9) | 32'h0000_007f;  // unknown opcode everywhere
            kind_a[i] = K_FILL;
            rd_a[i]   = '0;
            rs1_a[i]  = '0;
            rs2_a[i]  = '0;
            imm_a[i]  = '0;
            poison[i] = 1'b1;
        end
        r = $random(seed);
        add_inst(K_ADDI, 1, 0, 0, r);
        r = $random(seed);
        add_inst(K_LUI, 2, 0, 0, r);
        add_inst(K_ADD, 3, 1, 2, 0);  // each op reads the one before it
        add_inst(K_SUB, 4, 3, 1, 0);
        add_inst(K_AND, 5, 4, 2, 0);
        add_inst(K_OR, 6, 5, 3, 0);
        add_inst(K_XOR, 7, 6, 4, 0);
        r = $random(seed);
        add_inst(K_ADDI, 8, 7, 0, r);
        r = $random(seed);
        add_inst(K_LUI, 9, 0, 0, r);
        add_inst(K_ADD, 10, 9, 8, 0);
        r = $random(seed);
        add_inst(K_ADDI, 0, 10, 0, r);  // write to x0 is dropped
        add_inst(K_ADD, 11, 0, 10, 0);
        add_inst(K_BAD, 0, 0, 0, 0);
        add_inst(K_ADDI, 12, 11, 0, 32'h001);
        add_inst(K_BEQ, 0, 12, 12, 32'd12);  // taken
        add_skipped_word();
        add_skipped_word();
        add_inst(K_BNE, 0, 12, 12, 32'd8);  // falls through
        add_inst(K_JAL, 14, 0, 0, 32'd12);
        add_skipped_word();
        add_skipped_word();
        add_inst(K_ADD, 15, 14, 12, 0);
        add_inst(K_EBREAK, 0, 0, 0, 0);
    endtask

    // in-order ISA model over the recorded fields, no pipeline timing
    task run_model;
        logic [63:0] x [0:31];
        logic [63:0] res;
        logic [31:0] pc, next_pc, imm;
        logic [4:0]  rs1, rs2;
        int          idx, gap, steps;
        bit          unk, done, writes;
        for (int i = 0; i < 32; i++) begin
            x[i] = '0;
        end
        pc = 32'h0;
        done = 1'b0;
        steps = 0;
        while (!done && steps < 64) begin
            idx = pc[7:2];
            imm = imm_a[idx];
            rs1 = rs1_a[idx];
            rs2 = rs2_a[idx];
            res = '0;
            gap = 0;
            unk = 1'b0;
            next_pc = pc + 32'd4;
            writes = kind_a[idx] inside {K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_ADDI, K_LUI, K_JAL};
            case (kind_a[idx])
                K_ADD:  res = x[rs1] + x[rs2];
                K_SUB:  res = x[rs1] - x[rs2];
                K_AND:  res = x[rs1] & x[rs2];
                K_OR:   res = x[rs1] | x[rs2];
                K_XOR:  res = x[rs1] ^ x[rs2];
                K_ADDI: res = x[rs1] + {{52{imm[11]}}, imm[11:0]};
                K_LUI:  res = {{32{imm[19]}}, imm[19:0], 12'h000};
                K_BEQ, K_BNE: begin
                    if ((x[rs1] == x[rs2]) == (kind_a[idx] == K_BEQ)) begin
                        next_pc = pc + {{19{imm[12]}}, imm[12:0]};
                        gap = 2;
                    end
                end
                K_JAL: begin
                    res = {32'h0, pc + 32'd4};  // link value
                    next_pc = pc + {{11{imm[20]}}, imm[20:0]};
                    gap = 2;
                end
                K_EBREAK: done = 1'b1;
                default: unk = 1'b1;
            endcase
            if (writes && rd_a[idx] != 5'd0) begin
                x[rd_a[idx]] = res;
            end
            exp_pc.push_back(pc);
            exp_rd.push_back(writes ? rd_a[idx] : 5'd0);
            exp_data.push_back(res);
            exp_unk.push_back(unk);
            exp_gap.push_back(gap);
            pc = next_pc;
            steps++;
        end
    endtask

    always @(negedge clk) begin
        if (!reset_i && retire_valid_o) begin
            assert (!poison[retire_pc_o[7:2]]) else begin
                errors++;
                $display("** Error: retire_pc_o = %h is a word that must not retire", retire_pc_o);
            end
            if (exp_pc.size() == 0) begin
                errors++;
                $display("retirement at pc %h after the last expected instruction", retire_pc_o);
            end else begin
                e_pc = exp_pc.pop_front();
                e_rd = exp_rd.pop_front();
                e_data = exp_data.pop_front();
                e_unk = exp_unk.pop_front();
                if (retired > 0) begin
                    assert (bubbles == last_gap) else begin
                        errors++;
                        $display("** Error: retire_valid_o low for %h cycles before pc %h, expected %h",
                                 bubbles, e_pc, last_gap);
                    end
                end
                last_gap = exp_gap.pop_front();
                assert (retire_pc_o == e_pc) else begin
                    errors++;
                    $display("** Error: retire_pc_o = %h, expected %h", retire_pc_o, e_pc);
                end
                assert (retire_rd_o == e_rd) else begin
                    errors++;
                    $display("** Error: retire_rd_o = %h, expected %h at pc %h", retire_rd_o, e_rd, e_pc);
                end
                if (e_rd != 5'd0) begin
                    assert (retire_data_o == e_data) else begin
                        errors++;
                        $display("** Error: retire_data_o = %h, expected %h at pc %h",
                                 retire_data_o, e_data, e_pc);
                    end
                end
                assert (unknown_o == e_unk) else begin
                    errors++;
                    $display("** Error: unknown_o = %h, expected %h at pc %h", unknown_o, e_unk, e_pc);
                end
            end
            retired++;
            bubbles = 0;
        end else if (!reset_i) begin
            bubbles++;
        end
    end

    a_unknown_no_rd : assert property (@(posedge clk) disable iff (reset_i)
        unknown_o |-> retire_rd_o == 5'd0)
        else begin
            errors++;
            $display("** Error: retire_rd_o = %h with unknown_o high, expected %h",
                     $sampled(retire_rd_o), 5'h00);
        end

    a_halt_sticky : assert property (@(posedge clk) disable iff (reset_i)
        halted_o |=> halted_o)
        else begin
            errors++;
            $display("** Error: halted_o = %h after halt, expected %h", $sampled(halted_o), 1'b1);
        end

    a_halt_quiet : assert property (@(posedge clk) disable iff (reset_i)
        halted_o |-> !retire_valid_o)
        else begin
            errors++;
            $display("** Error: retire_valid_o = %h while halted, expected %h",
                     $sampled(retire_valid_o), 1'b0);
        end

    task wait_for_halt(input int limit);
        int n;
        n = 0;
        while (!halted_o && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!halted_o) begin
            errors++;
            $display("timeout: halted_o did not rise within %0d cycles", limit);
        end
    endtask

    task check_halt_window(input int cycles);
        logic [31:0] halt_pc;
        halt_pc = pc_o;
        repeat (cycles) begin
            @(negedge clk);
            assert (pc_o == halt_pc) else begin
                errors++;
                $display("** Error: pc_o = %h while halted, expected %h", pc_o, halt_pc);
            end
            assert (halted_o && !retire_valid_o) else begin
                errors++;
                $display("** Error: halted_o = %h retire_valid_o = %h, expected 1 and 0",
                         halted_o, retire_valid_o);
            end
        end
    endtask

    initial begin
        seed = 32'h3741_d49c;
        errors = 0;
        n_words = 0;
        build_program();
        run_model();
        repeat (7) @(posedge clk);
        @(negedge clk);
        assert (pc_o == 32'h0 && !retire_valid_o && !unknown_o && !halted_o) else begin
            errors++;
            $display("** Error: after reset pc_o = %h retire_valid_o = %h unknown_o = %h halted_o = %h",
                     pc_o, retire_valid_o, unknown_o, halted_o);
        end
        @(posedge clk);
        #1 reset_i = 1'b0;
        wait_for_halt(100);
        check_halt_window(20);
        if (exp_pc.size() != 0) begin
            errors++;
            $display("%0d expected retirements never appeared", exp_pc.size());
        end
        $display("retire checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- flist.f
verilog/rvmini_pkg.sv
verilog/rvmini_pipe_if.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/reg_file.sv
verilog/rvmini_top.sv
verification/rvmini_tb.sv

//--- Bender.yml
package:
  name: rvmini

sources:
  - verilog/rvmini_pkg.sv
  - verilog/rvmini_pipe_if.sv
  - verilog/fetch_stage.sv
  - verilog/decode_stage.sv
  - verilog/execute_stage.sv
  - verilog/reg_file.sv
  - verilog/rvmini_top.sv
  - target: test
    files:
      - verification/rvmini_tb.sv
